/* verif/bridgeGolden.txt */
# test op dir burst sel arg w0 w1 w2 w3 (decimal fields, hex words)
# op 0 regWr 1 regRd 2 cpuWr 3 cpuRd 4 cpuPost 5 cpuWait 6 pciWr 7 pciRd 8 block 9 quiet 10 reset 11 end
1 0 0 0 0 1 00000021 00000000 00000000 00000000
1 1 0 0 0 3 00000021 00000000 00000000 00000000
1 0 0 0 0 3 00000031 00000000 00000000 00000000
1 1 0 0 0 4 00000031 00000000 00000000 00000000
1 0 0 0 0 4 00000001 00000000 00000000 00000000
1 1 0 0 0 1 00000001 00000000 00000000 00000000
1 11 0 0 0 0 00000000 00000000 00000000 00000000
2 2 1 0 0 0 11111111 00000000 00000000 00000000
2 2 1 1 0 0 22222222 33333333 44444444 55555555
2 1 1 0 1 0 00000005 00000000 00000000 00000000
2 7 1 0 0 2 11111111 22222222 00000000 00000000
2 1 1 0 1 0 00000003 00000000 00000000 00000000
2 7 1 0 0 3 33333333 44444444 55555555 00000000
2 1 1 0 1 0 00000100 00000000 00000000 00000000
2 11 0 0 0 0 00000000 00000000 00000000 00000000
3 6 0 0 0 4 a0000001 a0000002 a0000003 a0000004
3 3 0 1 0 0 a0000001 a0000002 a0000003 a0000004
3 1 0 0 1 0 00000100 00000000 00000000 00000000
3 6 0 0 0 3 b0000001 b0000002 b0000003 00000000
3 4 0 1 1 0 b0000001 b0000002 b0000003 b0000004
3 9 0 0 0 6 00000000 00000000 00000000 00000000
3 6 0 0 0 1 b0000004 00000000 00000000 00000000
3 5 0 0 0 0 00000000 00000000 00000000 00000000
3 1 0 0 1 0 00000100 00000000 00000000 00000000
3 11 0 0 0 0 00000000 00000000 00000000 00000000
4 6 0 0 0 4 c0000000 c0000001 c0000002 c0000003
4 6 0 0 0 4 c0000004 c0000005 c0000006 c0000007
4 1 0 0 1 0 00000208 00000000 00000000 00000000
4 8 0 0 0 4 deadbeef 00000000 00000000 00000000
4 1 0 0 1 0 00000608 00000000 00000000 00000000
4 0 0 0 1 0 00000000 00000000 00000000 00000000
4 1 0 0 1 0 00000208 00000000 00000000 00000000
4 3 0 1 0 0 c0000000 c0000001 c0000002 c0000003
4 3 0 1 0 0 c0000004 c0000005 c0000006 c0000007
4 1 0 0 1 0 00000100 00000000 00000000 00000000
4 11 0 0 0 0 00000000 00000000 00000000 00000000
5 0 0 0 0 0 00000000 00000000 00000000 00000000
5 1 0 0 0 0 00000000 00000000 00000000 00000000
5 4 1 0 0 0 e0000001 00000000 00000000 00000000
5 9 1 0 0 8 00000000 00000000 00000000 00000000
5 10 0 0 0 0 00000000 00000000 00000000 00000000
5 5 0 0 0 0 00000000 00000000 00000000 00000000
5 1 0 0 0 0 00000001 00000000 00000000 00000000
5 1 0 0 1 0 00000100 00000000 00000000 00000000
5 11 0 0 0 0 00000000 00000000 00000000 00000000

/* build.f */
design/bridgePkg.sv
design/dataFifo.sv
design/bridgeRegs.sv
design/transferAck.sv
design/busSteer.sv
design/busBridge.sv
verif/bridgeChecker.sv
verif/bridgeTb.sv

/* verif/bridgeTb.sv */
/*
 * Bridge testbench
 * Replays the golden record file against the bridge, drives
 * both buses on the falling edge and guards the run with a timeout
 */

`timescale 1ns/100ps

module bridgeTb;

    localparam int resetCycles = 16;
    localparam int maxRecords = 128;

    // Record operations, one per golden line
    localparam int opRegWrite = 0;
    localparam int opRegRead = 1;
    localparam int opCpuWrite = 2;
    localparam int opCpuRead = 3;
    localparam int opCpuPost = 4;
    localparam int opCpuWait = 5;
    localparam int opPciWrite = 6;
    localparam int opPciRead = 7;
    localparam int opPciBlocked = 8;
    localparam int opQuiet = 9;
    localparam int opReset = 10;
    localparam int opEndTest = 11;

    logic BCLK = 1'b0;
    logic TS_RESET = 1'b1;
    logic ts = 1'b0;
    logic rnw = 1'b0;
    logic burst = 1'b0;
    logic regSel = 1'b0;
    logic regOffset = 1'b0;
    logic [bridgePkg::dataWidth-1:0] cpuDataIn = '0;
    logic pciDir = 1'b0;
    logic irdy = 1'b0;
    logic [bridgePkg::dataWidth-1:0] pciAdIn = '0;
    logic ta;
    logic [bridgePkg::dataWidth-1:0] cpuDataOut;
    logic cpuDataOe;
    logic trdy;
    logic [bridgePkg::dataWidth-1:0] pciAdOut;
    logic pciAdOe;

    // Golden records
    int recCount = 0;
    int recTest [maxRecords];
    int recOp [maxRecords];
    int recDir [maxRecords];
    int recBurst [maxRecords];
    int recSel [maxRecords];
    int recArg [maxRecords];
    logic [bridgePkg::dataWidth-1:0] recWord [maxRecords*4];

    int cycles = 0;
    int cycleLimit = 1000000;
    int testsRun = 0;
    logic cpuBusy = 1'b0;
    int fd;

    busBridge i_dut (
        .BCLK(BCLK), .TS_RESET(TS_RESET),
        .ts(ts), .rnw(rnw), .burst(burst), .regSel(regSel), .regOffset(regOffset),
        .cpuDataIn(cpuDataIn), .ta(ta), .cpuDataOut(cpuDataOut), .cpuDataOe(cpuDataOe),
        .pciDir(pciDir), .irdy(irdy), .pciAdIn(pciAdIn),
        .trdy(trdy), .pciAdOut(pciAdOut), .pciAdOe(pciAdOe)
    );

    bridgeChecker i_check (
        .BCLK(BCLK), .TS_RESET(TS_RESET), .ts(ts), .ta(ta),
        .cpuDataOut(cpuDataOut), .cpuDataOe(cpuDataOe),
        .irdy(irdy), .trdy(trdy), .pciAdOut(pciAdOut), .pciAdOe(pciAdOe)
    );

    // 20 ns clock
    always #10 BCLK = ~BCLK;

    ////////////////////
    // Timeout
    ////////////////////

    always @(posedge BCLK) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout, the run went past %0d cycles", cycleLimit);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////
    // Golden file
    ////////////////////

    task automatic loadRecords();
        logic [8*200-1:0] line;
        int n;
        int f [6];
        logic [bridgePkg::dataWidth-1:0] w [4];
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%d %d %d %d %d %d %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], w[0], w[1], w[2], w[3]);
            // Comment lines fail the scan and drop out here
            if (n == 10 && recCount < maxRecords) begin
                recTest[recCount] = f[0];
                recOp[recCount] = f[1];
                recDir[recCount] = f[2];
                recBurst[recCount] = f[3];
                recSel[recCount] = f[4];
                recArg[recCount] = f[5];
                for (int j = 0; j < 4; j++) begin
                    recWord[recCount*4 + j] = w[j];
                end
                recCount++;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////
    // Bus drivers
    ////////////////////

    // One CPU cycle, a new beat word is offered at each falling edge
    task automatic cpuTransfer(input int r, input logic rd, input logic isReg);
        int beats;
        int k;
        beats = (recBurst[r] != 0 && !isReg) ? bridgePkg::burstBeats : 1;
        k = 0;
        i_check.expectTa(beats);
        if (rd) begin
            for (int j = 0; j < beats; j++) begin
                i_check.expectCpu(recWord[r*4 + j]);
            end
        end
        if (isReg) begin
            i_check.expectLatency(recArg[r]);
        end
        ts = 1'b1;
        rnw = rd;
        burst = (recBurst[r] != 0);
        regSel = isReg;
        regOffset = recSel[r][0];
        cpuDataIn = recWord[r*4];
        @(negedge BCLK);
        ts = 1'b0;
        while (k < beats && !TS_RESET) begin
            cpuDataIn = recWord[r*4 + k];
            #1;
            if (ta) begin
                k++;
            end
            @(negedge BCLK);
        end
        // Reset dropped the rest of the transfer
        if (k < beats) begin
            i_check.cancelTa(beats - k);
        end
    endtask

    // Holds irdy until the given number of words have moved
    task automatic pciTransfer(input int r, input logic rd);
        int k;
        k = 0;
        if (rd) begin
            for (int j = 0; j < recArg[r]; j++) begin
                i_check.expectPci(recWord[r*4 + j]);
            end
        end
        irdy = 1'b1;
        while (k < recArg[r]) begin
            pciAdIn = recWord[r*4 + k];
            #1;
            if (trdy) begin
                k++;
            end
            @(negedge BCLK);
        end
        irdy = 1'b0;
    endtask

    ////////////////////
    // Record player
    ////////////////////

    task automatic runRecord(input int r);
        if (recOp[r] != opCpuWait && recOp[r] != opEndTest) begin
            pciDir = recDir[r][0];
        end
        case (recOp[r])
            opRegWrite: cpuTransfer(r, 1'b0, 1'b1);
            opRegRead: cpuTransfer(r, 1'b1, 1'b1);
            opCpuWrite: cpuTransfer(r, 1'b0, 1'b0);
            opCpuRead: cpuTransfer(r, 1'b1, 1'b0);
            opCpuPost: begin
                // Runs alongside the PCI records that follow
                cpuBusy = 1'b1;
                fork
                    begin
                        cpuTransfer(r, recSel[r][0], 1'b0);
                        cpuBusy = 1'b0;
                    end
                join_none
                @(negedge BCLK);
            end
            opCpuWait: begin
                wait (cpuBusy == 1'b0);
                @(negedge BCLK);
            end
            opPciWrite: pciTransfer(r, 1'b0);
            opPciRead: pciTransfer(r, 1'b1);
            opPciBlocked: begin
                irdy = 1'b1;
                pciAdIn = recWord[r*4];
                i_check.expectBlocked(recArg[r]);
                repeat (recArg[r]) @(negedge BCLK);
                irdy = 1'b0;
                @(negedge BCLK);
            end
            opQuiet: begin
                i_check.expectQuiet(recArg[r]);
                repeat (recArg[r]) @(negedge BCLK);
            end
            opReset: begin
                TS_RESET = 1'b1;
                repeat (4) @(negedge BCLK);
                TS_RESET = 1'b0;
                @(negedge BCLK);
            end
            opEndTest: begin
                i_check.closeTest(recTest[r]);
                testsRun++;
            end
            default: $display("record %0d has an unknown operation %0d", r, recOp[r]);
        endcase
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        fd = $fopen("verif/bridgeGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden record file");
            $display("tests failed");
            $finish;
        end else begin
            loadRecords();
            cycleLimit = recCount * (bridgePkg::burstBeats + 8) + resetCycles;
            repeat (resetCycles) @(negedge BCLK);
            TS_RESET = 1'b0;
            @(negedge BCLK);
            for (int r = 0; r < recCount; r++) begin
                runRecord(r);
            end
            $display("tests run %0d, with errors %0d, error count %0d",
                     testsRun, i_check.failedTests, i_check.totalErrors);
            if (testsRun > 0 && i_check.failedTests == 0 && i_check.totalErrors == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

/* verif/bridgeChecker.sv */
/*
 * Bridge checker
 * Watches the DUT ports and compares read data, ta counts,
 * ta latency and stall windows against what the testbench expects
 */

`timescale 1ns/100ps

module bridgeChecker (
    input  logic                            BCLK,
    input  logic                            TS_RESET,
    input  logic                            ts,
    input  logic                            ta,
    input  logic [bridgePkg::dataWidth-1:0] cpuDataOut,
    input  logic                            cpuDataOe,
    input  logic                            irdy,
    input  logic                            trdy,
    input  logic [bridgePkg::dataWidth-1:0] pciAdOut,
    input  logic                            pciAdOe
);

    // Words still owed on each bus, oldest first
    logic [bridgePkg::dataWidth-1:0] cpuExpect [$];
    logic [bridgePkg::dataWidth-1:0] pciExpect [$];
    logic [bridgePkg::dataWidth-1:0] want;

    int cycle = 0;
    int tsCycle = 0;
    int latWant = 0;
    int taSeen = 0;
    int taWant = 0;
    int quietLeft = 0;
    int blockLeft = 0;
    int testErrors = 0;
    int totalErrors = 0;
    int failedTests = 0;
    logic latArmed = 1'b0;

    ////////////////////
    // Expectations
    ////////////////////

    task automatic expectCpu(input logic [bridgePkg::dataWidth-1:0] word);
        cpuExpect.push_back(word);
    endtask

    task automatic expectPci(input logic [bridgePkg::dataWidth-1:0] word);
        pciExpect.push_back(word);
    endtask

    task automatic expectTa(input int n);
        taWant += n;
    endtask

    // Beats of a transfer that reset threw away
    task automatic cancelTa(input int n);
        taWant -= n;
    endtask

    // Cycles from the ts edge to the first ta edge, 0 skips the check
    task automatic expectLatency(input int n);
        latWant = n;
    endtask

    task automatic expectQuiet(input int n);
        quietLeft = n;
    endtask

    task automatic expectBlocked(input int n);
        blockLeft = n;
    endtask

    ////////////////////
    // Port monitor
    ////////////////////

    // Sampled on the rising edge, inputs move on the falling edge
    always @(posedge BCLK) begin
        cycle++;
        if (!TS_RESET) begin
            if (ts) begin
                tsCycle = cycle;
                latArmed = (latWant != 0);
            end
            if (ta) begin
                taSeen++;
                if (latArmed) begin
                    if (cycle - tsCycle != latWant) begin
                        $display("error %0t ns: first ta after %0d cycles, expected %0d",
                                 $time, cycle - tsCycle, latWant);
                        testErrors++;
                    end
                    latArmed = 1'b0;
                    latWant = 0;
                end
                if (quietLeft > 0) begin
                    $display("at %0t ns a held transfer was acknowledged", $time);
                    testErrors++;
                end
                if (cpuDataOe) begin
                    if (cpuExpect.size() == 0) begin
                        $display("at %0t ns a CPU read beat came with no word expected", $time);
                        testErrors++;
                    end else begin
                        want = cpuExpect.pop_front();
                        if (cpuDataOut !== want) begin
                            $display("error %0t ns: cpuDataOut %h, expected %h",
                                     $time, cpuDataOut, want);
                            testErrors++;
                        end
                    end
                end
            end
            if (blockLeft > 0 && trdy) begin
                $display("at %0t ns trdy rose although the FIFO is full", $time);
                testErrors++;
            end
            if (irdy && trdy && pciAdOe) begin
                if (pciExpect.size() == 0) begin
                    $display("at %0t ns a PCI read moved with no word expected", $time);
                    testErrors++;
                end else begin
                    want = pciExpect.pop_front();
                    if (pciAdOut !== want) begin
                        $display("error %0t ns: pciAdOut %h, expected %h",
                                 $time, pciAdOut, want);
                        testErrors++;
                    end
                end
            end
        end
        if (quietLeft > 0) begin
            quietLeft--;
        end
        if (blockLeft > 0) begin
            blockLeft--;
        end
    end

    ////////////////////
    // Test boundary
    ////////////////////

    task automatic closeTest(input int num);
        if (taSeen != taWant) begin
            $display("test %0d: wrong number of ta pulses, saw %0d of %0d", num, taSeen, taWant);
            testErrors++;
        end
        if (cpuExpect.size() != 0) begin
            $display("test %0d: %0d CPU read words never returned", num, cpuExpect.size());
            testErrors++;
        end
        if (pciExpect.size() != 0) begin
            $display("test %0d: %0d PCI read words never moved", num, pciExpect.size());
            testErrors++;
        end
        if (testErrors == 0) begin
            $display("test %0d finished ok", num);
        end else begin
            $display("test %0d finished with %0d errors", num, testErrors);
            failedTests++;
        end
        totalErrors += testErrors;
        testErrors = 0;
        taSeen = 0;
        taWant = 0;
        cpuExpect.delete();
        pciExpect.delete();
    endtask

endmodule

/* design/busBridge.sv */
/*
 * CPU to PCI data bridge top
 * Ties the register block, transfer sequencer,
 * bus steering and data FIFO together
 */

`timescale 1ns/100ps

module busBridge (
    input  logic                           BCLK,
    input  logic                           TS_RESET,
    // CPU side
    input  logic                           ts,
    input  logic                           rnw,
    input  logic                           burst,
    input  logic                           regSel,
    input  logic                           regOffset,
    input  logic [bridgePkg::dataWidth-1:0] cpuDataIn,
    output logic                           ta,
    output logic [bridgePkg::dataWidth-1:0] cpuDataOut,
    output logic                           cpuDataOe,
    // PCI side
    input  logic                           pciDir,
    input  logic                           irdy,
    input  logic [bridgePkg::dataWidth-1:0] pciAdIn,
    output logic                           trdy,
    output logic [bridgePkg::dataWidth-1:0] pciAdOut,
    output logic                           pciAdOe
);

    ////////////////////
    // Internal nets
    ////////////////////

    // FIFO state
    logic [bridgePkg::dataWidth-1:0] fifoHead;
    logic [bridgePkg::levelBits-1:0] level;
    logic empty;
    logic full;

    // Register block
    logic [bridgePkg::dataWidth-1:0] regData;
    logic enable;
    logic [bridgePkg::waitBits-1:0] waitStates;

    // Sequencer
    logic beat;
    logic isReg;

    // Steering
    logic fifoPush;
    logic fifoPop;
    logic [bridgePkg::dataWidth-1:0] fifoWrData;
    logic regWrite;
    logic overrun;

    ////////////////////
    // Instances
    ////////////////////

    bridgeRegs i_regs (
        .BCLK(BCLK), .TS_RESET(TS_RESET),
        .regWrite(regWrite), .regOffset(regOffset), .wrData(cpuDataIn),
        .level(level), .empty(empty), .full(full), .overrun(overrun),
        .rdData(regData), .enable(enable), .waitStates(waitStates)
    );

    transferAck i_ack (
        .BCLK(BCLK), .TS_RESET(TS_RESET),
        .ts(ts), .rnw(rnw), .burst(burst), .regSel(regSel), .pciDir(pciDir),
        .enable(enable), .waitStates(waitStates), .level(level),
        .ta(ta), .beat(beat), .isReg(isReg)
    );

    busSteer i_steer (
        .beat(beat), .isReg(isReg), .rnw(rnw), .pciDir(pciDir), .irdy(irdy),
        .full(full), .empty(empty),
        .cpuDataIn(cpuDataIn), .pciAdIn(pciAdIn),
        .fifoHead(fifoHead), .regData(regData),
        .fifoPush(fifoPush), .fifoPop(fifoPop), .fifoWrData(fifoWrData),
        .regWrite(regWrite), .overrun(overrun), .trdy(trdy),
        .cpuDataOut(cpuDataOut), .cpuDataOe(cpuDataOe),
        .pciAdOut(pciAdOut), .pciAdOe(pciAdOe)
    );

    dataFifo i_fifo (
        .BCLK(BCLK), .TS_RESET(TS_RESET),
        .push(fifoPush), .pop(fifoPop), .wrData(fifoWrData),
        .rdData(fifoHead), .level(level), .empty(empty), .full(full)
    );

endmodule

/* design/busSteer.sv */
/*
 * Bus steering
 * Routes FIFO fill and drain per direction and drives
 * CPU read data, trdy and both output enables
 */

`timescale 1ns/100ps

module busSteer (
    input  logic                           beat,
    input  logic                           isReg,
    input  logic                           rnw,
    input  logic                           pciDir,
    input  logic                           irdy,
    input  logic                           full,
    input  logic                           empty,
    input  logic [bridgePkg::dataWidth-1:0] cpuDataIn,
    input  logic [bridgePkg::dataWidth-1:0] pciAdIn,
    input  logic [bridgePkg::dataWidth-1:0] fifoHead,
    input  logic [bridgePkg::dataWidth-1:0] regData,
    output logic                           fifoPush,
    output logic                           fifoPop,
    output logic [bridgePkg::dataWidth-1:0] fifoWrData,
    output logic                           regWrite,
    output logic                           overrun,
    output logic                           trdy,
    output logic [bridgePkg::dataWidth-1:0] cpuDataOut,
    output logic                           cpuDataOe,
    output logic [bridgePkg::dataWidth-1:0] pciAdOut,
    output logic                           pciAdOe
);

    logic fifoBeat;
    logic pciMove;

    // CPU beats that touch the FIFO rather than the registers
    assign fifoBeat = beat && !isReg;

    // Target ready only in an initiator data phase
    // pciDir high means PCI drains, low means PCI fills
    assign trdy = irdy && (pciDir ? !empty : !full);
    assign pciMove = irdy && trdy;

    // Fill side follows direction
    assign fifoPush = pciDir ? (fifoBeat && !rnw) : pciMove;
    assign fifoWrData = pciDir ? cpuDataIn : pciAdIn;

    // Drain side is the opposite bus
    assign fifoPop = pciDir ? pciMove : (fifoBeat && rnw);

    // PCI tried to write into a full buffer
    assign overrun = !pciDir && irdy && full;

    assign regWrite = beat && isReg && !rnw;

    // CPU read data and enable
    assign cpuDataOut = isReg ? regData : fifoHead;
    assign cpuDataOe = beat && rnw;

    // PCI AD driven while the bridge sources data
    assign pciAdOut = fifoHead;
    assign pciAdOe = pciDir && irdy;

endmodule

/* design/transferAck.sv */
/*
 * CPU transfer sequencer
 * Latches ts, counts wait states, waits for FIFO room or data
 * and issues one ta or a four-beat burst of ta pulses
 */

`timescale 1ns/100ps

module transferAck (
    input  logic                           BCLK,
    input  logic                           TS_RESET,
    input  logic                           ts,
    input  logic                           rnw,
    input  logic                           burst,
    input  logic                           regSel,
    input  logic                           pciDir,
    input  logic                           enable,
    input  logic [bridgePkg::waitBits-1:0]  waitStates,
    input  logic [bridgePkg::levelBits-1:0] level,
    output logic                           ta,
    output logic                           beat,
    output logic                           isReg
);

    // Start latch, held until the last beat
    logic pending;
    // Remaining beats of a burst after the first
    logic inBurst;

    // Transfer attributes captured with ts
    logic rnwHeld;
    logic burstHeld;
    logic regHeld;

    logic [bridgePkg::waitBits-1:0] waitCnt;
    logic [bridgePkg::beatBits-1:0] beatCnt;

    logic canGo;
    logic firstAck;
    logic burstMode;

    ////////////////////
    // FIFO room check
    ////////////////////

    // Whole transfer must fit before the first beat
    // Later beats never need a recheck since the far side only helps
    always_comb begin : roomCheck
        int need;
        int room;
        need = burstHeld ? bridgePkg::burstBeats : 1;
        room = bridgePkg::fifoDepth - int'(level);
        if (rnwHeld) begin
            // CPU read drains words that PCI wrote toward the CPU
            canGo = !pciDir && (int'(level) >= need);
        end else begin
            // CPU write fills words headed for PCI
            canGo = pciDir && (room >= need);
        end
    end

    // Register cycles bypass both enable and the FIFO condition
    assign burstMode = burstHeld && !regHeld;
    assign firstAck = pending && !inBurst && (waitCnt == '0)
                      && (regHeld || (enable && canGo));

    ////////////////////
    // Acknowledge
    ////////////////////

    assign ta = firstAck || inBurst;
    assign beat = ta;
    assign isReg = regHeld;

    ////////////////////
    // Sequencer state
    ////////////////////

    always_ff @(posedge BCLK or posedge TS_RESET) begin
        if (TS_RESET) begin
            pending <= 1'b0;
            inBurst <= 1'b0;
            rnwHeld <= 1'b0;
            burstHeld <= 1'b0;
            regHeld <= 1'b0;
            waitCnt <= '0;
            beatCnt <= '0;
        end else if (!pending) begin
            // Idle, take a new start
            if (ts) begin
                pending <= 1'b1;
                waitCnt <= waitStates;
                rnwHeld <= rnw;
                burstHeld <= burst;
                regHeld <= regSel;
            end
        end else if (inBurst) begin
            // Burst beats run back to back
            if (beatCnt == bridgePkg::lastBeat) begin
                inBurst <= 1'b0;
                pending <= 1'b0;
                beatCnt <= '0;
            end else begin
                beatCnt <= beatCnt + 1'b1;
            end
        end else if (waitCnt != '0) begin
            waitCnt <= waitCnt - 1'b1;
        end else if (firstAck) begin
            if (burstMode) begin
                inBurst <= 1'b1;
                beatCnt <= beatCnt + 1'b1;
            end else begin
                pending <= 1'b0;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Every ta traces back to a sampled or latched start
    assert property (@(posedge BCLK) disable iff (TS_RESET)
        ta |-> $past(pending) || $past(ts))
        else $error("ta without a latched transfer start");

    // Burst gives exactly burstBeats pulses in a row
    assert property (@(posedge BCLK) disable iff (TS_RESET)
        $rose(ta) && burstMode |-> ta [* bridgePkg::burstBeats] ##1 !ta)
        else $error("burst ta count wrong");

    // Single and register cycles give one pulse
    assert property (@(posedge BCLK) disable iff (TS_RESET)
        $rose(ta) && !burstMode |=> !ta)
        else $error("single cycle gave more than one ta");

endmodule

/* design/bridgeRegs.sv */
/*
 * Bridge control and status registers
 * Holds enable and wait-state count, reports FIFO level
 * and a sticky overrun flag
 */

`timescale 1ns/100ps

module bridgeRegs (
    input  logic                           BCLK,
    input  logic                           TS_RESET,
    input  logic                           regWrite,
    input  logic                           regOffset,
    input  logic [bridgePkg::dataWidth-1:0] wrData,
    input  logic [bridgePkg::levelBits-1:0] level,
    input  logic                           empty,
    input  logic                           full,
    input  logic                           overrun,
    output logic [bridgePkg::dataWidth-1:0] rdData,
    output logic                           enable,
    output logic [bridgePkg::waitBits-1:0]  waitStates
);

    // Sticky copy of the overrun event
    logic overrunFlag;

    // Write strobes per offset
    logic ctrlWrite;
    logic statWrite;

    assign ctrlWrite = regWrite && (regOffset == bridgePkg::regCtrlOffset);
    assign statWrite = regWrite && (regOffset == bridgePkg::regStatOffset);

    ////////////////////
    // Control register
    ////////////////////

    // Bridge comes up enabled with no wait states
    always_ff @(posedge BCLK or posedge TS_RESET) begin
        if (TS_RESET) begin
            enable <= 1'b1;
            waitStates <= '0;
        end else if (ctrlWrite) begin
            enable <= wrData[bridgePkg::ctrlEnableBit];
            waitStates <= wrData[bridgePkg::ctrlWaitLsb +: bridgePkg::waitBits];
        end
    end

    ////////////////////
    // Overrun flag
    ////////////////////

    // Any write to status clears it
    // New event in the same cycle wins so nothing is lost
    always_ff @(posedge BCLK or posedge TS_RESET) begin
        if (TS_RESET) begin
            overrunFlag <= 1'b0;
        end else if (overrun) begin
            overrunFlag <= 1'b1;
        end else if (statWrite) begin
            overrunFlag <= 1'b0;
        end
    end

    ////////////////////
    // Read mux
    ////////////////////

    always_comb begin
        rdData = '0;
        if (regOffset == bridgePkg::regStatOffset) begin
            // Live FIFO state plus the sticky flag
            rdData[bridgePkg::statLevelLsb +: bridgePkg::levelBits] = level;
            rdData[bridgePkg::statEmptyBit] = empty;
            rdData[bridgePkg::statFullBit] = full;
            rdData[bridgePkg::statOverrunBit] = overrunFlag;
        end else begin
            // Control readback
            rdData[bridgePkg::ctrlEnableBit] = enable;
            rdData[bridgePkg::ctrlWaitLsb +: bridgePkg::waitBits] = waitStates;
        end
    end

endmodule

/* design/dataFifo.sv */
/*
 * Bridge data FIFO
 * Eight-entry synchronous first-word-fall-through buffer
 * with an occupancy count for status and flow control
 */

`timescale 1ns/100ps

module dataFifo (
    input  logic                           BCLK,
    input  logic                           TS_RESET,
    input  logic                           push,
    input  logic                           pop,
    input  logic [bridgePkg::dataWidth-1:0] wrData,
    output logic [bridgePkg::dataWidth-1:0] rdData,
    output logic [bridgePkg::levelBits-1:0] level,
    output logic                           empty,
    output logic                           full
);

    // Word storage
    logic [bridgePkg::dataWidth-1:0] mem [bridgePkg::fifoDepth];

    // Pointers wrap naturally at the power-of-two depth
    logic [bridgePkg::ptrBits-1:0] wrPtr;
    logic [bridgePkg::ptrBits-1:0] rdPtr;

    // Number of valid entries
    logic [bridgePkg::levelBits-1:0] count;

    ////////////////////
    // Storage write
    ////////////////////

    always_ff @(posedge BCLK) begin
        if (push) begin
            mem[wrPtr] <= wrData;
        end
    end

    ////////////////////
    // Pointers and count
    ////////////////////

    always_ff @(posedge BCLK or posedge TS_RESET) begin
        if (TS_RESET) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // Outputs
    ////////////////////

    // Head word falls through and is popped in the same cycle it is taken
    assign rdData = mem[rdPtr];
    assign level = count;
    assign empty = (count == '0);
    assign full = (count == bridgePkg::fullLevel);

    ////////////////////
    // Checks
    ////////////////////

    // Steering and the sequencer must never overfill the buffer
    assert property (@(posedge BCLK) disable iff (TS_RESET)
        push |-> !full)
        else $error("FIFO push while full");

    // A drain beat needs a word waiting
    assert property (@(posedge BCLK) disable iff (TS_RESET)
        pop |-> !empty)
        else $error("FIFO pop while empty");

endmodule

/* design/bridgePkg.sv */
/*
 * Bridge package
 * Widths, FIFO depth, burst length and register map shared by the
 * CPU to PCI bridge blocks
 */

package bridgePkg;

    ////////////////////
    // Data path sizes
    ////////////////////

    // One bus word on either side
    localparam int dataWidth = 32;

    // FIFO entries and derived pointer width
    localparam int fifoDepth = 8;
    localparam int ptrBits = $clog2(fifoDepth);

    // Level count must hold 0..fifoDepth
    localparam int levelBits = 4;
    localparam logic [levelBits-1:0] fullLevel = levelBits'(fifoDepth);

    ////////////////////
    // CPU transfers
    ////////////////////

    // A 68040 line burst is four beats
    localparam int burstBeats = 4;
    localparam int beatBits = $clog2(burstBeats);
    localparam logic [beatBits-1:0] lastBeat = beatBits'(burstBeats - 1);

    // Programmed wait states before the first ta
    localparam int waitBits = 2;

    ////////////////////
    // Register map
    ////////////////////

    localparam logic regCtrlOffset = 1'b0;
    localparam logic regStatOffset = 1'b1;

    // Control word fields
    localparam int ctrlEnableBit = 0;
    localparam int ctrlWaitLsb = 4;

    // Status word fields
    localparam int statLevelLsb = 0;
    localparam int statEmptyBit = 8;
    localparam int statFullBit = 9;
    localparam int statOverrunBit = 10;

endpackage
